/* filelist.f */
+incdir+source
source/mpu_pkg.sv
source/mpu_if.sv
source/mpu_decoder.sv
source/mpu_registers.sv
source/mpu_execution.sv
source/mpu_top.sv
test/mpu_checker.sv
test/mpu_tb.sv

/* source/mpu_decoder.sv */
`include "mpu_defs.svh"

module mpu_decoder (
  input  logic [`MPU_INSTR_W-1:0] instr,
  mpu_op_if.decoder               op_bus
);
  import mpu_pkg::*;

  // Field layout, from bit 47 down: opcode, rd, ra, rb, imm
  localparam int OPC_W  = $bits(mpu_opcode_e);
  localparam int OPC_HI = `MPU_INSTR_W - 1;
  localparam int RD_HI  = OPC_HI - OPC_W;
  localparam int RA_HI  = RD_HI - `MPU_RIDX_W;
  localparam int RB_HI  = RA_HI - `MPU_RIDX_W;

  logic [OPC_W-1:0] op_raw;

  assign op_raw = instr[OPC_HI -: OPC_W];

  // Register indices
  assign op_bus.rd = instr[RD_HI -: `MPU_RIDX_W];
  assign op_bus.ra = instr[RA_HI -: `MPU_RIDX_W];
  assign op_bus.rb = instr[RB_HI -: `MPU_RIDX_W];

  // Immediate sits in the low bits
  assign op_bus.imm = instr[`MPU_IMM_W-1:0];

  // Codes past HALT are undefined and run as NOP
  always_comb begin
    case (op_raw)
      OP_NOP,
      OP_LDI,
      OP_ADD,
      OP_XOR,
      OP_AND,
      OP_LD,
      OP_BNE,
      OP_JMP,
      OP_IRQ,
      OP_HALT: begin
        op_bus.op = mpu_opcode_e'(op_raw);
      end
      default: begin
        op_bus.op = OP_NOP;
      end
    endcase
  end

endmodule

/* source/mpu_defs.svh */
`ifndef MPU_DEFS_SVH
`define MPU_DEFS_SVH

// Instruction memory
`define MPU_IADDR_W 16
`define MPU_INSTR_W 48

// Data path and host address width
`define MPU_DATA_W 64

// Register file geometry
`define MPU_REG_N 16
`define MPU_RIDX_W 4

// Immediate field, zero-extended into the data path
`define MPU_IMM_W 32

`endif

/* source/mpu_execution.sv */
`include "mpu_defs.svh"

module mpu_execution (
  input  logic                    sys_clk,
  input  logic                    reset,

  // Decoded instruction and register file
  mpu_op_if.execution             op_bus,
  mpu_reg_if.master               regs,

  // Instruction fetch address
  output logic [`MPU_IADDR_W-1:0] i_addr,

  // Host memory read handshake
  output logic [`MPU_DATA_W-1:0]  hm_addr,
  output logic                    hm_start,
  input  logic [`MPU_DATA_W-1:0]  hm_data,
  input  logic                    hm_en,

  // User interrupt handshake
  output logic                    user_irq,
  output logic [`MPU_DATA_W-1:0]  user_data,
  input  logic                    user_en
);
  import mpu_pkg::*;

  mpu_state_e             state;
  logic [`MPU_IADDR_W-1:0] pc;
  logic [`MPU_RIDX_W-1:0]  wait_rd;

  logic [`MPU_DATA_W-1:0]  imm_ext;
  logic [`MPU_DATA_W-1:0]  alu_result;
  logic                    writes_rd;
  logic                    branch_taken;
  logic [`MPU_IADDR_W-1:0] target;

  assign i_addr = pc;

  assign imm_ext = {{(`MPU_DATA_W - `MPU_IMM_W){1'b0}}, op_bus.imm};
  assign target  = op_bus.imm[`MPU_IADDR_W-1:0];

  // Operand fetch straight from the decoded fields
  assign regs.ra_idx = op_bus.ra;
  assign regs.rb_idx = op_bus.rb;

  // ALU, ADD wraps at 64 bits
  always_comb begin
    writes_rd = 1'b1;
    case (op_bus.op)
      OP_LDI: alu_result = imm_ext;
      OP_ADD: alu_result = regs.ra_data + regs.rb_data;
      OP_XOR: alu_result = regs.ra_data ^ regs.rb_data;
      OP_AND: alu_result = regs.ra_data & regs.rb_data;
      default: begin
        alu_result = '0;
        writes_rd  = 1'b0;
      end
    endcase
  end

  assign branch_taken = (op_bus.op == OP_JMP) ||
                        ((op_bus.op == OP_BNE) && (regs.ra_data != regs.rb_data));

  // Write port, host data lands at the acknowledge edge
  always_comb begin
    if (state == S_WAIT_MEM) begin
      regs.w_idx  = wait_rd;
      regs.w_data = hm_data;
      regs.we     = hm_en;
    end else begin
      regs.w_idx  = op_bus.rd;
      regs.w_data = alu_result;
      regs.we     = (state == S_EXECUTE) && writes_rd;
    end
  end

  // Sequencer and program counter
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      state    <= S_FETCH;
      pc       <= '0;
      hm_start <= 1'b0;
      user_irq <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          state <= S_EXECUTE;
        end
        S_EXECUTE: begin
          case (op_bus.op)
            OP_LD: begin
              state    <= S_WAIT_MEM;
              hm_start <= 1'b1;
            end
            OP_IRQ: begin
              state    <= S_WAIT_USER;
              user_irq <= 1'b1;
            end
            OP_HALT: begin
              // pc stays on the HALT word
              state <= S_HALTED;
            end
            default: begin
              state <= S_FETCH;
              pc    <= branch_taken ? target : pc + 1'b1;
            end
          endcase
        end
        S_WAIT_MEM: begin
          if (hm_en) begin
            state    <= S_FETCH;
            hm_start <= 1'b0;
            pc       <= pc + 1'b1;
          end
        end
        S_WAIT_USER: begin
          if (user_en) begin
            state    <= S_FETCH;
            user_irq <= 1'b0;
            pc       <= pc + 1'b1;
          end
        end
        S_HALTED: begin
          state <= S_HALTED;
        end
        default: begin
          state <= S_FETCH;
        end
      endcase
    end
  end

  // Request payloads, held for the whole wait
  always_ff @(posedge sys_clk) begin
    if (state == S_EXECUTE) begin
      wait_rd <= op_bus.rd;
      if (op_bus.op == OP_LD) begin
        hm_addr <= regs.ra_data;
      end
      if (op_bus.op == OP_IRQ) begin
        user_data <= regs.ra_data;
      end
    end
  end

endmodule

/* source/mpu_if.sv */
`include "mpu_defs.svh"

// Decoded instruction fields, combinational from the fetched word
interface mpu_op_if;
  import mpu_pkg::*;

  mpu_opcode_e             op;
  logic [`MPU_RIDX_W-1:0]  rd;
  logic [`MPU_RIDX_W-1:0]  ra;
  logic [`MPU_RIDX_W-1:0]  rb;
  logic [`MPU_IMM_W-1:0]   imm;

  modport decoder (
    output op, rd, ra, rb, imm
  );

  modport execution (
    input op, rd, ra, rb, imm
  );
endinterface

// Register file access, two async reads and one clocked write
interface mpu_reg_if;
  logic [`MPU_RIDX_W-1:0] ra_idx;
  logic [`MPU_RIDX_W-1:0] rb_idx;
  logic [`MPU_DATA_W-1:0] ra_data;
  logic [`MPU_DATA_W-1:0] rb_data;
  logic [`MPU_RIDX_W-1:0] w_idx;
  logic [`MPU_DATA_W-1:0] w_data;
  logic                   we;

  modport master (
    output ra_idx, rb_idx, w_idx, w_data, we,
    input  ra_data, rb_data
  );

  modport regfile (
    input  ra_idx, rb_idx, w_idx, w_data, we,
    output ra_data, rb_data
  );
endinterface

/* source/mpu_pkg.sv */
package mpu_pkg;

  // Opcodes, top 4 bits of the instruction word
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_LDI  = 4'd1,
    OP_ADD  = 4'd2,
    OP_XOR  = 4'd3,
    OP_AND  = 4'd4,
    OP_LD   = 4'd5,
    OP_BNE  = 4'd6,
    OP_JMP  = 4'd7,
    OP_IRQ  = 4'd8,
    OP_HALT = 4'd9
  } mpu_opcode_e;

  // Sequencer states
  typedef enum logic [2:0] {
    S_FETCH,
    S_EXECUTE,
    S_WAIT_MEM,
    S_WAIT_USER,
    S_HALTED
  } mpu_state_e;

endpackage

/* source/mpu_registers.sv */
`include "mpu_defs.svh"

module mpu_registers (
  input logic        sys_clk,
  input logic        reset,
  mpu_reg_if.regfile regs
);

  logic [`MPU_DATA_W-1:0] mem [`MPU_REG_N];

  // Both read ports are combinational
  assign regs.ra_data = mem[regs.ra_idx];
  assign regs.rb_data = mem[regs.rb_idx];

  // Single write port, all registers cleared on reset
  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < `MPU_REG_N; i++) begin
        mem[i] <= '0;
      end
    end else if (regs.we) begin
      mem[regs.w_idx] <= regs.w_data;
    end
  end

endmodule

/* source/mpu_top.sv */
`include "mpu_defs.svh"

module mpu_top (
  // System
  input  logic                    sys_clk,
  input  logic                    reset,

  // Synchronous instruction memory
  output logic [`MPU_IADDR_W-1:0] i_addr,
  input  logic [`MPU_INSTR_W-1:0] i_data,

  // Interrupts to the user
  output logic                    user_irq,
  output logic [`MPU_DATA_W-1:0]  user_data,
  input  logic                    user_en,

  // Host memory under check, acknowledged by hm_en
  output logic [`MPU_DATA_W-1:0]  hm_addr,
  output logic                    hm_start,
  input  logic [`MPU_DATA_W-1:0]  hm_data,
  input  logic                    hm_en
);

  mpu_op_if  op_bus ();
  mpu_reg_if reg_bus ();

  // Field extraction
  mpu_decoder decoder (
    .instr  (i_data),
    .op_bus (op_bus.decoder)
  );

  // Sequencer, ALU and outside handshakes
  mpu_execution execution (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .op_bus    (op_bus.execution),
    .regs      (reg_bus.master),
    .i_addr    (i_addr),
    .hm_addr   (hm_addr),
    .hm_start  (hm_start),
    .hm_data   (hm_data),
    .hm_en     (hm_en),
    .user_irq  (user_irq),
    .user_data (user_data),
    .user_en   (user_en)
  );

  // General purpose registers
  mpu_registers registers (
    .sys_clk (sys_clk),
    .reset   (reset),
    .regs    (reg_bus.regfile)
  );

endmodule

/* test/mpu_checker.sv */
`include "mpu_defs.svh"

module mpu_checker (
  input  logic                          sys_clk,
  input  logic                          reset,
  input  logic [`MPU_IADDR_W-1:0]       i_addr,
  input  logic                          user_irq,
  input  logic [`MPU_DATA_W-1:0]        user_data,
  input  logic                          hm_start,
  input  logic [`MPU_DATA_W-1:0]        hm_addr,
  input  logic [64*`MPU_INSTR_W-1:0]    prog_flat,
  input  logic                          prog_ready,
  input  logic                          run_done,
  output int                            value_errors,
  output int                            event_errors,
  output int                            exp_steps
);
  timeunit 1ns;
  timeprecision 100ps;
  import mpu_pkg::*;

  localparam int PROG_N = 64;
  localparam logic [`MPU_DATA_W-1:0] HOST_KEY = 64'hA5C3_96E1_0F1E_2D3C;

  // Outside events in program order, bit 64 set for an IRQ
  logic [`MPU_DATA_W:0]    exp_events [$];
  int                      ref_halt_pc;
  int                      ev_count;
  logic                    req_prev;
  logic                    in_reset;
  logic                    halt_seen;
  logic                    final_done;
  logic [`MPU_DATA_W-1:0]  held_data;
  logic [`MPU_IADDR_W-1:0] held_pc;

  // Host memory contents: address xor key, rotated left by 8
  function automatic logic [`MPU_DATA_W-1:0] host_rule(input logic [`MPU_DATA_W-1:0] addr);
    logic [`MPU_DATA_W-1:0] x;
    x = addr ^ HOST_KEY;
    return {x[55:0], x[63:56]};
  endfunction

  // Instruction set model, returns the number of executed instructions
  function automatic int run_reference();
    logic [`MPU_DATA_W-1:0]  rf [`MPU_REG_N];
    logic [`MPU_INSTR_W-1:0] w;
    logic [3:0]              op;
    logic [31:0]             imm;
    int                      rd;
    int                      ra;
    int                      rb;
    int                      pc;
    int                      steps;
    bit                      running;
    foreach (rf[i]) begin
      rf[i] = '0;
    end
    pc = 0;
    steps = 0;
    running = 1'b1;
    while (running && steps < 4096) begin
      w = prog_flat[(pc % PROG_N) * `MPU_INSTR_W +: `MPU_INSTR_W];
      op = w[47:44];
      rd = w[43:40];
      ra = w[39:36];
      rb = w[35:32];
      imm = w[31:0];
      steps++;
      pc++;
      case (op)
        OP_LDI: rf[rd] = {32'h0, imm};
        OP_ADD: rf[rd] = rf[ra] + rf[rb];
        OP_XOR: rf[rd] = rf[ra] ^ rf[rb];
        OP_AND: rf[rd] = rf[ra] & rf[rb];
        OP_LD: begin
          exp_events.push_back({1'b0, rf[ra]});
          rf[rd] = host_rule(rf[ra]);
        end
        OP_BNE: begin
          if (rf[ra] != rf[rb]) begin
            pc = imm[15:0];
          end
        end
        OP_JMP: pc = imm[15:0];
        OP_IRQ: exp_events.push_back({1'b1, rf[ra]});
        OP_HALT: begin
          ref_halt_pc = pc - 1;
          running = 1'b0;
        end
        // NOP and undefined codes change nothing
        default: ;
      endcase
    end
    if (running) begin
      $display("Reference model did not reach HALT within %0d steps", steps);
      event_errors++;
    end
    return steps;
  endfunction

  task automatic value_mismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("CHECK FAILED time %0d ns signal %s expected %h actual %h",
             $time, name, expected, actual);
    value_errors++;
  endtask

  task automatic other_failure(input string what);
    $display("Error at %0d ns: %s", $time, what);
    event_errors++;
  endtask

  task automatic check_reset_values();
    if (i_addr !== '0) value_mismatch("i_addr", '0, i_addr);
    if (hm_start !== 1'b0) value_mismatch("hm_start", 0, hm_start);
    if (user_irq !== 1'b0) value_mismatch("user_irq", 0, user_irq);
  endtask

  task automatic watch_requests();
    logic                   req;
    logic                   is_irq;
    logic [`MPU_DATA_W-1:0] data;
    string                  name;
    req = hm_start | user_irq;
    is_irq = user_irq;
    data = is_irq ? user_data : hm_addr;
    name = is_irq ? "user_data" : "hm_addr";
    if (hm_start && user_irq) other_failure("hm_start and user_irq are high together");
    if (req && !req_prev) begin
      if (halt_seen) other_failure($sformatf("%s request after HALT", name));
      if (ev_count >= exp_events.size()) begin
        other_failure($sformatf("%s request beyond the %0d expected events",
                                name, exp_events.size()));
      end else if (exp_events[ev_count][64] != is_irq) begin
        other_failure($sformatf("event %0d is a %s request, the program expects the other kind",
                                ev_count, name));
      end else if (data !== exp_events[ev_count][63:0]) begin
        value_mismatch(name, exp_events[ev_count][63:0], data);
      end
      ev_count++;
      held_data = data;
      held_pc = i_addr;
    end else if (req) begin
      // Still waiting for the acknowledge
      if (data !== held_data) value_mismatch(name, held_data, data);
      if (i_addr !== held_pc) value_mismatch("i_addr", held_pc, i_addr);
    end
    req_prev = req;
  endtask

  task automatic watch_halt();
    if (halt_seen && i_addr !== ref_halt_pc[`MPU_IADDR_W-1:0]) begin
      value_mismatch("i_addr", ref_halt_pc[`MPU_IADDR_W-1:0], i_addr);
    end
    if (i_addr === ref_halt_pc[`MPU_IADDR_W-1:0]) halt_seen = 1'b1;
  endtask

  task automatic final_counts();
    if (ev_count != exp_events.size()) begin
      other_failure($sformatf("%0d requests observed, %0d expected",
                              ev_count, exp_events.size()));
    end
    if (!halt_seen) other_failure("the DUT never fetched the HALT instruction");
  endtask

  initial begin
    value_errors = 0;
    event_errors = 0;
    exp_steps = 0;
    ev_count = 0;
    req_prev = 1'b0;
    in_reset = 1'b0;
    halt_seen = 1'b0;
    final_done = 1'b0;
    ref_halt_pc = -1;
    wait (prog_ready);
    exp_steps = run_reference();
  end

  // Samples the values the DUT held before each rising edge
  always @(posedge sys_clk) begin
    if (reset) begin
      // Nothing is loaded before the first reset edge
      if (in_reset) check_reset_values();
      in_reset = 1'b1;
      req_prev = 1'b0;
    end else begin
      if (in_reset) check_reset_values();
      in_reset = 1'b0;
      watch_requests();
      watch_halt();
      if (run_done && !final_done) begin
        final_counts();
        final_done = 1'b1;
      end
    end
  end

endmodule

/* test/mpu_tb.sv */
`include "mpu_defs.svh"

module mpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mpu_pkg::*;

  localparam int PROG_N = 64;
  localparam int CYCLES_PER_INSTR = 2 + 6;
  localparam logic [`MPU_DATA_W-1:0] HOST_KEY = 64'hA5C3_96E1_0F1E_2D3C;

  logic                    sys_clk;
  logic                    reset;
  logic [`MPU_IADDR_W-1:0] i_addr;
  logic [`MPU_INSTR_W-1:0] i_data;
  logic                    user_irq;
  logic [`MPU_DATA_W-1:0]  user_data;
  logic                    user_en;
  logic [`MPU_DATA_W-1:0]  hm_addr;
  logic                    hm_start;
  logic [`MPU_DATA_W-1:0]  hm_data;
  logic                    hm_en;

  logic [`MPU_INSTR_W-1:0]        prog [PROG_N];
  logic [PROG_N*`MPU_INSTR_W-1:0] prog_flat;
  logic                           prog_ready;
  logic                           run_done;
  int                             value_errors;
  int                             event_errors;
  int                             exp_steps;
  int                             wp;
  int                             halt_pc;

  mpu_top DUT (
    .sys_clk   (sys_clk),
    .reset     (reset),
    .i_addr    (i_addr),
    .i_data    (i_data),
    .user_irq  (user_irq),
    .user_data (user_data),
    .user_en   (user_en),
    .hm_addr   (hm_addr),
    .hm_start  (hm_start),
    .hm_data   (hm_data),
    .hm_en     (hm_en)
  );

  mpu_checker scoreboard (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .i_addr       (i_addr),
    .user_irq     (user_irq),
    .user_data    (user_data),
    .hm_start     (hm_start),
    .hm_addr      (hm_addr),
    .prog_flat    (prog_flat),
    .prog_ready   (prog_ready),
    .run_done     (run_done),
    .value_errors (value_errors),
    .event_errors (event_errors),
    .exp_steps    (exp_steps)
  );

  function automatic logic [`MPU_INSTR_W-1:0] encode(input logic [3:0] op, input int rd,
                                                     input int ra, input int rb,
                                                     input logic [31:0] imm);
    return {op, rd[3:0], ra[3:0], rb[3:0], imm};
  endfunction

  function automatic logic [`MPU_DATA_W-1:0] host_word(input logic [`MPU_DATA_W-1:0] addr);
    logic [`MPU_DATA_W-1:0] mixed;
    mixed = addr ^ HOST_KEY;
    return {mixed[55:0], mixed[63:56]};
  endfunction

  task automatic put_word(input logic [`MPU_INSTR_W-1:0] word);
    prog[wp] = word;
    wp++;
  endtask

  task automatic build_program();
    int         rx;
    int         ry;
    int         loop_pc;
    logic [3:0] bad_op;
    wp = 0;
    // Unused words hold HALT with their own address in imm
    for (int i = 0; i < PROG_N; i++) begin
      prog[i] = encode(OP_HALT, 0, 0, 0, i);
    end
    rx = 1 + $urandom % 2;
    ry = 7 + $urandom % 2;
    put_word(encode(OP_LDI, rx, 0, 0, $urandom));
    put_word(encode(OP_LDI, ry, 0, 0, $urandom));
    put_word(encode(OP_ADD, 3, rx, ry, 0));
    put_word(encode(OP_XOR, 4, rx, ry, 0));
    put_word(encode(OP_AND, 5, ry, rx, 0));
    put_word(encode(OP_IRQ, 0, 3, 0, 0));
    put_word(encode(OP_IRQ, 0, 4, 0, 0));
    put_word(encode(OP_IRQ, 0, 5, 0, 0));
    // Undefined opcode aimed at r4
    bad_op = 10 + $urandom % 6;
    put_word(encode(bad_op, 4, 3, rx, $urandom));
    put_word(encode(OP_IRQ, 0, 4, 0, 0));
    // Equal operands so the branch back to 0 falls through
    put_word(encode(OP_BNE, 0, rx, rx, 0));
    put_word(encode(OP_JMP, 0, 0, 0, wp + 2));
    put_word(encode(OP_LDI, 3, 0, 0, 32'hDEAD_BEEF));
    put_word(encode(OP_IRQ, 0, 3, 0, 0));
    // Counted loop where r6 doubles until it wraps past 64 bits
    put_word(encode(OP_LDI, 9, 0, 0, 0));
    put_word(encode(OP_LDI, 10, 0, 0, 34 + $urandom % 4));
    put_word(encode(OP_LDI, 11, 0, 0, 1));
    put_word(encode(OP_LDI, 6, 0, 0, $urandom | 32'h8000_0000));
    loop_pc = wp;
    put_word(encode(OP_ADD, 6, 6, 6, 0));
    put_word(encode(OP_ADD, 9, 9, 11, 0));
    put_word(encode(OP_IRQ, 0, 6, 0, 0));
    put_word(encode(OP_BNE, 0, 9, 10, loop_pc));
    // Host reads with the second from a full 64-bit address
    put_word(encode(OP_LDI, 13, 0, 0, $urandom));
    put_word(encode(OP_LD, 14, 13, 0, 0));
    put_word(encode(OP_IRQ, 0, 14, 0, 0));
    put_word(encode(OP_LD, 15, 6, 0, 0));
    put_word(encode(OP_IRQ, 0, 15, 0, 0));
    put_word(encode(OP_XOR, 12, 14, 15, 0));
    put_word(encode(OP_IRQ, 0, 12, 0, 0));
    halt_pc = wp;
    put_word(encode(OP_HALT, 0, 0, 0, 0));
    for (int i = 0; i < PROG_N; i++) begin
      prog_flat[i*`MPU_INSTR_W +: `MPU_INSTR_W] = prog[i];
    end
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  // Synchronous instruction memory
  always @(posedge sys_clk) begin
    i_data <= prog[i_addr[5:0]];
  end

  initial begin : host_memory
    int delay;
    forever begin
      @(negedge sys_clk);
      if (hm_start === 1'b1) begin
        delay = $urandom % 5;
        repeat (delay) @(negedge sys_clk);
        hm_data = host_word(hm_addr);
        hm_en = 1'b1;
        @(negedge sys_clk);
        hm_en = 1'b0;
        hm_data = '0;
      end
    end
  end

  initial begin : user_responder
    int delay;
    forever begin
      @(negedge sys_clk);
      if (user_irq === 1'b1) begin
        delay = $urandom % 6;
        repeat (delay) @(negedge sys_clk);
        user_en = 1'b1;
        @(negedge sys_clk);
        user_en = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (prog_ready);
    @(negedge sys_clk);
    limit = exp_steps * CYCLES_PER_INSTR + 20;
    repeat (limit) @(posedge sys_clk);
    $display("Watchdog expired after %0d cycles, the run did not reach HALT", limit);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main_sequence
    int unsigned seed;
    reset = 1'b1;
    user_en = 1'b0;
    hm_en = 1'b0;
    hm_data = '0;
    i_data = '0;
    prog_ready = 1'b0;
    run_done = 1'b0;
    seed = 44;
    void'($urandom(seed));
    build_program();
    prog_ready = 1'b1;
    repeat (2) @(posedge sys_clk);
    @(negedge sys_clk);
    reset = 1'b0;
    wait (i_addr == halt_pc);
    // Quiet period after HALT
    repeat (10) @(negedge sys_clk);
    run_done = 1'b1;
    repeat (2) @(negedge sys_clk);
    $display("Errors: %0d value, %0d event", value_errors, event_errors);
    if (value_errors + event_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
